/* build.f */
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/memory_stage.sv
logic/processor.sv
tests/processor_tb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/register_file.sv
      - logic/execute_unit.sv
      - logic/memory_stage.sv
      - logic/processor.sv
  - target: test
    files:
      - tests/processor_tb.sv

/* tests/processor_tb.sv */
`timescale 1ns/1ns
/*
 random 64-word program and 256-word data memory, checked against an
 in-order instruction model
 fetch order assumes two words are fetched behind each branch
 data addresses reach the data memory through their low eight bits
*/
module processor_tb import isa_pkg::*; ();
    localparam logic [word_size-1:0] start_addr = 16'h0040;
    localparam int prog_len = 64;
    localparam int mem_words = 256;
    localparam int cycle_limit = prog_len * (5 + 3 + 4) + 100;
    localparam int num_tests = 6;
    localparam int t_reset = 0;
    localparam int t_store = 1;
    localparam int t_load = 2;
    localparam int t_fetch = 3;
    localparam int t_hold = 4;
    localparam int t_count = 5;

    logic Clock, Reset;
    logic [word_size-1:0] instr_addr, instr_in, data_addr, data_out, data_in;
    logic data_read, data_write, data_done;

    logic [word_size-1:0] imem [prog_len];
    logic [word_size-1:0] dmem [mem_words];
    logic [1:0] delays [mem_words];          // extra wait cycles per access
    logic [32:0] exp_acc [$];                // {write, address, store data}
    logic [word_size-1:0] exp_fetch [$];
    logic [word_size-1:0] fetch_rel, last_fetch, seen_fetch;
    int checks [num_tests];
    int errors [num_tests];
    string test_names [num_tests] = '{"reset", "stores", "loads", "fetch", "hold", "count"};
    int exp_total, acc_seen, acc_done, cycles, wait_left, total_checks, total_errors;
    logic pending, req_read, req_write;
    logic [word_size-1:0] req_addr, req_data, req_pc;

    // instruction memory answers in the same cycle and reads nops outside the program
    assign fetch_rel = instr_addr - start_addr;
    assign instr_in = (fetch_rel < prog_len) ? imem[fetch_rel[5:0]] : '0;

    processor #(.reset_addr(start_addr)) processor_i (
        .Clock(Clock), .Reset(Reset), .instr_in(instr_in), .data_in(data_in),
        .data_done(data_done), .instr_addr(instr_addr), .data_addr(data_addr),
        .data_out(data_out), .data_read(data_read), .data_write(data_write)
    );

    always #10 Clock = ~Clock;

    task automatic compare_value(input string name, input logic [word_size-1:0] got,
                                 input logic [word_size-1:0] exp, input int test);
        checks[test]++;
        if (got !== exp) begin
            errors[test]++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int test);
        $display("test %s: %0d checks, %0d errors", test_names[test], checks[test], errors[test]);
    endtask

    task automatic build_program();
        logic [2:0] sel, x, y;
        logic [8:0] imm;
        logic imm_form;
        int limit;
        for (int k = 0; k < prog_len; k++) begin
            sel = 3'($urandom % 8);
            x = 3'($urandom % 8);
            y = 3'($urandom % 8);
            imm = 9'($urandom);
            imm_form = 1'($urandom % 2);
            case (sel)
                3'd1: begin
                    limit = prog_len - 1 - k;           // never past the program end
                    imm = 9'((limit < 3) ? limit : $urandom % 4);
                    imem[k] = {op_branch, 1'b0, 3'($urandom % 7), imm};
                end
                3'd6: imem[k] = imm_form ? {op_other, 1'b1, x, imm}
                                         : {op_other, 1'b0, x, 6'd0, y};
                3'd7: imem[k] = {op_store, imm_form, x, imm_form ? imm : {6'd0, y}};
                default: imem[k] = {sel, imm_form, x, imm_form ? imm : {6'd0, y}};
            endcase
        end
    endtask

    task automatic note_fetch(input logic [word_size-1:0] rel);
        if (rel != last_fetch) begin
            exp_fetch.push_back(start_addr + rel);
            last_fetch = rel;
        end
    endtask

    // in-order model that fills the expected accesses and the fetch order
    task automatic run_model();
        logic [word_size-1:0] r [num_regs];
        logic [word_size-1:0] mem [mem_words];
        logic [word_size-1:0] w, imm, op2, diff, pc, next;
        logic [2:0] x;
        logic fn, fz, fc, take;
        pc = '0;
        fn = 1'b0;
        fz = 1'b0;
        fc = 1'b0;
        take = 1'b0;
        last_fetch = '0;
        for (int i = 0; i < num_regs; i++)
            r[i] = '0;
        for (int i = 0; i < mem_words; i++)
            mem[i] = dmem[i];
        while (pc < prog_len) begin
            note_fetch(pc);
            w = imem[pc[5:0]];
            x = w[11:9];
            imm = {{7{w[8]}}, w[8:0]};
            op2 = w[12] ? imm : r[w[2:0]];
            next = pc + 1;
            case (w[15:13])
                3'd0: r[x] = op2;
                3'd1: if (!w[12] && x != 3'd7) begin
                    case (x)
                        3'd0: take = 1'b1;
                        3'd1: take = fz;
                        3'd2: take = !fz;
                        3'd3: take = !fc;
                        3'd4: take = fc;
                        3'd5: take = !fn;   // result not negative
                        default: take = fn;
                    endcase
                    note_fetch(pc + 1);
                    note_fetch(pc + 2);
                    if (take)
                        next = pc + 1 + imm;
                end
                3'd2: r[x] = r[x] + op2;
                3'd3: r[x] = r[x] - op2;
                3'd4: begin
                    r[x] = mem[op2[7:0]];
                    exp_acc.push_back({1'b0, op2, 16'h0000});
                end
                3'd5: begin
                    mem[op2[7:0]] = r[x];
                    exp_acc.push_back({1'b1, op2, r[x]});
                end
                3'd7: if (w[12] || w[8:3] == '0) begin
                    diff = r[x] - op2;
                    fn = diff[word_size-1];
                    fz = diff == '0;
                    fc = r[x] >= op2;
                end
                default: ;
            endcase
            pc = next;
        end
    endtask

    task automatic check_access();
        logic [32:0] e;
        if (exp_acc.size() == 0) begin
            $display("data access at %0t ns after the model ran out of accesses", $time);
            errors[t_count]++;
        end else begin
            e = exp_acc.pop_front();
            if (e[32]) begin
                compare_value("data_write", data_write, 1, t_store);
                compare_value("data_addr", data_addr, e[31:16], t_store);
                compare_value("data_out", data_out, e[15:0], t_store);
            end else begin
                compare_value("data_read", data_read, 1, t_load);
                compare_value("data_addr", data_addr, e[31:16], t_load);
            end
        end
    endtask

    // data memory answers after 1 to 4 cycles
    always @(posedge Clock) begin
        if (!Reset) begin
            if (data_read || data_write) begin
                if (!pending) begin
                    pending = 1'b1;
                    wait_left = delays[acc_seen % mem_words];
                    acc_seen++;
                    req_addr = data_addr;
                    req_data = data_out;
                    req_read = data_read;
                    req_write = data_write;
                    req_pc = instr_addr;
                    check_access();
                end else begin
                    compare_value("data_addr", data_addr, req_addr, t_hold);
                    compare_value("data_out", data_out, req_data, t_hold);
                    compare_value("data_read", data_read, req_read, t_hold);
                    compare_value("data_write", data_write, req_write, t_hold);
                    compare_value("instr_addr", instr_addr, req_pc, t_hold);
                end
                if (data_done) begin               // completes on this edge
                    if (data_write)
                        dmem[data_addr[7:0]] = data_out;
                    pending = 1'b0;
                    acc_done++;
                    data_done <= 1'b0;
                end else if (wait_left == 0) begin
                    data_in <= dmem[data_addr[7:0]];
                    data_done <= 1'b1;
                end else begin
                    wait_left--;
                end
            end else if (pending) begin
                $display("request at %0t ns was withdrawn before data_done", $time);
                errors[t_hold]++;
                pending = 1'b0;
                data_done <= 1'b0;
            end
        end
    end

    always @(posedge Clock) begin
        if (!Reset && instr_addr !== seen_fetch) begin
            seen_fetch = instr_addr;
            if (exp_fetch.size() > 0)
                compare_value("instr_addr", instr_addr, exp_fetch.pop_front(), t_fetch);
        end
    end

    always @(posedge Clock) begin
        if (!Reset) begin
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: program did not finish within %0d cycles", cycle_limit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(32'h6ce3_4343));
        Clock = 1'b0;
        Reset = 1'b1;
        data_in = '0;
        data_done = 1'b0;
        pending = 1'b0;
        acc_seen = 0;
        acc_done = 0;
        cycles = 0;
        wait_left = 0;
        seen_fetch = start_addr;
        for (int t = 0; t < num_tests; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] = 16'($urandom);
            delays[i] = 2'($urandom % 4);
        end
        build_program();
        run_model();
        exp_total = exp_acc.size();

        repeat (16) @(posedge Clock);
        compare_value("instr_addr", instr_addr, start_addr, t_reset);
        compare_value("data_read", data_read, 0, t_reset);
        compare_value("data_write", data_write, 0, t_reset);
        report_test(t_reset);
        Reset <= 1'b0;

        // the last program word has retired once fetch is well past the end
        while (fetch_rel < prog_len + 8)
            @(posedge Clock);
        compare_value("access count", 16'(acc_done), 16'(exp_total), t_count);
        if (exp_fetch.size() != 0) begin
            $display("fetch never reached %0d of the expected addresses", exp_fetch.size());
            errors[t_fetch]++;
        end
        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t < num_tests; t++)
            report_test(t);
        for (int t = 0; t < num_tests; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("%0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end
endmodule

/* logic/processor.sv */
`timescale 1ns/1ns
/*
 five-stage in-order core: fetch, decode, execute, memory, writeback
 instruction memory answers in the same cycle as instr_addr
 a slow data access stalls the whole pipeline, fetch included
 after a branch, fetch waits until the branch has retired
*/
module processor import isa_pkg::*, pipe_pkg::*; #(
    parameter logic [word_size-1:0] reset_addr = '0
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic [word_size-1:0] instr_in,
    input  logic [word_size-1:0] data_in,
    input  logic                 data_done,
    output logic [word_size-1:0] instr_addr,
    output logic [word_size-1:0] data_addr,
    output logic [word_size-1:0] data_out,
    output logic                 data_read,
    output logic                 data_write
);
    logic hold, stall, branch_busy, redirect;
    logic [word_size-1:0] redirect_addr;
    logic fetch_valid;
    logic [word_size-1:0] fetch_word, fetch_pc;
    logic [reg_bits-1:0] raddr_x, raddr_y;
    logic [word_size-1:0] rdata_x, rdata_y;
    // decode register, the instruction now in execute
    logic d_valid, d_wb_en, d_set_flags, d_read, d_write, d_branch;
    logic [reg_bits-1:0] d_rd;
    logic [word_size-1:0] d_op1, d_op2, d_pc;
    alu_op_t d_alu_op;
    cond_t d_cond;
    // execute register, the instruction now in memory
    logic e_valid, e_wb_en, e_read, e_write, e_branch, e_taken;
    logic [reg_bits-1:0] e_rd;
    logic [word_size-1:0] e_result, e_op2, e_target;
    logic wb_en;
    logic [reg_bits-1:0] wb_rd;
    logic [word_size-1:0] wb_data;

    assign branch_busy = d_branch || e_branch || redirect;

    fetch_unit #(.reset_addr(reset_addr)) fetch_i (
        .Clock(Clock), .Reset(Reset), .hold(hold), .stall(stall),
        .branch_busy(branch_busy), .redirect(redirect), .redirect_addr(redirect_addr),
        .instr_in(instr_in), .instr_addr(instr_addr), .fetch_valid(fetch_valid),
        .fetch_word(fetch_word), .fetch_pc(fetch_pc)
    );

    decode_unit decode_i (
        .Clock(Clock), .Reset(Reset), .hold(hold), .branch_busy(branch_busy),
        .fetch_valid(fetch_valid), .fetch_word(fetch_word), .fetch_pc(fetch_pc),
        .rdata_x(rdata_x), .rdata_y(rdata_y),
        .ex_rd(d_rd), .ex_wb(d_wb_en), .mem_rd(e_rd), .mem_wb(e_wb_en),
        .wbk_rd(wb_rd), .wbk_wb(wb_en),
        .raddr_x(raddr_x), .raddr_y(raddr_y), .stall(stall),
        .valid(d_valid), .rd(d_rd), .wb_en(d_wb_en), .op1(d_op1), .op2(d_op2),
        .alu_op(d_alu_op), .set_flags(d_set_flags), .read(d_read), .write(d_write),
        .branch(d_branch), .cond(d_cond), .pc(d_pc)
    );

    register_file regs_i (
        .Clock(Clock), .Reset(Reset), .raddr_x(raddr_x), .raddr_y(raddr_y),
        .wen(wb_en), .waddr(wb_rd), .wdata(wb_data),
        .rdata_x(rdata_x), .rdata_y(rdata_y)
    );

    execute_unit execute_i (
        .Clock(Clock), .Reset(Reset), .hold(hold),
        .d_valid(d_valid), .d_rd(d_rd), .d_wb_en(d_wb_en), .d_op1(d_op1), .d_op2(d_op2),
        .d_alu_op(d_alu_op), .d_set_flags(d_set_flags), .d_read(d_read),
        .d_write(d_write), .d_branch(d_branch), .d_cond(d_cond), .d_pc(d_pc),
        .valid(e_valid), .rd(e_rd), .wb_en(e_wb_en), .result(e_result), .op2(e_op2),
        .read(e_read), .write(e_write), .branch(e_branch), .taken(e_taken),
        .target(e_target)
    );

    memory_stage memory_i (
        .Clock(Clock), .Reset(Reset), .data_in(data_in), .data_done(data_done),
        .e_valid(e_valid), .e_rd(e_rd), .e_wb_en(e_wb_en), .e_result(e_result),
        .e_op2(e_op2), .e_read(e_read), .e_write(e_write), .e_branch(e_branch),
        .e_taken(e_taken), .e_target(e_target),
        .data_addr(data_addr), .data_out(data_out), .data_read(data_read),
        .data_write(data_write), .hold(hold), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data), .redirect(redirect), .redirect_addr(redirect_addr)
    );
endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ns
/*
 memory stage and the writeback register
 a request stays on the port until data_done, and hold freezes every
 stage register meanwhile, data_done without a request is ignored
 a branch leaves its redirect address in wb_data
*/
module memory_stage import isa_pkg::*; (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic [word_size-1:0] data_in,
    input  logic                 data_done,
    input  logic                 e_valid,
    input  logic [reg_bits-1:0]  e_rd,
    input  logic                 e_wb_en,
    input  logic [word_size-1:0] e_result,
    input  logic [word_size-1:0] e_op2,
    input  logic                 e_read,
    input  logic                 e_write,
    input  logic                 e_branch,
    input  logic                 e_taken,
    input  logic [word_size-1:0] e_target,
    output logic [word_size-1:0] data_addr,
    output logic [word_size-1:0] data_out,
    output logic                 data_read,
    output logic                 data_write,
    output logic                 hold,
    output logic                 wb_en,
    output logic [reg_bits-1:0]  wb_rd,
    output logic [word_size-1:0] wb_data,
    output logic                 redirect,
    output logic [word_size-1:0] redirect_addr
);
    logic wb_valid, wb_branch;

    assign data_read = e_valid && e_read;
    assign data_write = e_valid && e_write;
    assign data_addr = e_op2;
    assign data_out = e_result;      // rX for a store
    assign hold = (data_read || data_write) && !data_done;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            wb_valid <= 1'b0;
            wb_en <= 1'b0;
            wb_branch <= 1'b0;
        end else if (!hold) begin
            wb_valid <= e_valid;
            wb_en <= e_wb_en;
            wb_branch <= e_branch;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            wb_rd <= e_rd;
            if (e_read)
                wb_data <= data_in;
            else if (e_branch && e_taken)
                wb_data <= e_target;
            else
                wb_data <= e_result;
        end
    end

    // one cycle, nothing behind a branch can hold the writeback register
    assign redirect = wb_valid && wb_branch;
    assign redirect_addr = wb_data;

    assert property (@(posedge Clock) disable iff (Reset) !(data_read && data_write));
endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ns
/*
 ALU, flags and branch resolution, one cycle
 only cmp writes the flags, and a branch tests the flags as they stand
 a branch leaves pc+1 in result so a not-taken branch can still redirect
*/
module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 hold,
    input  logic                 d_valid,
    input  logic [reg_bits-1:0]  d_rd,
    input  logic                 d_wb_en,
    input  logic [word_size-1:0] d_op1,
    input  logic [word_size-1:0] d_op2,
    input  alu_op_t              d_alu_op,
    input  logic                 d_set_flags,
    input  logic                 d_read,
    input  logic                 d_write,
    input  logic                 d_branch,
    input  cond_t                d_cond,
    input  logic [word_size-1:0] d_pc,
    output logic                 valid,
    output logic [reg_bits-1:0]  rd,
    output logic                 wb_en,
    output logic [word_size-1:0] result,
    output logic [word_size-1:0] op2,
    output logic                 read,
    output logic                 write,
    output logic                 branch,
    output logic                 taken,
    output logic [word_size-1:0] target
);
    logic [word_size:0] diff;        // top bit is the carry and stays high without a borrow
    logic [word_size-1:0] alu_y, next_pc;
    logic [num_flags-1:0] flags;
    logic cond_ok;

    assign diff = {1'b0, d_op1} + {1'b0, ~d_op2} + 1'b1;
    assign next_pc = d_pc + 1'b1;

    always_comb begin
        case (d_alu_op)
            alu_pass: alu_y = d_op2;
            alu_add:  alu_y = d_op1 + d_op2;
            alu_sub:  alu_y = diff[word_size-1:0];
            default:  alu_y = d_op1;   // rX rides along as store data
        endcase
    end

    always_comb begin
        case (d_cond)
            cond_none: cond_ok = 1'b1;
            cond_eq:   cond_ok = flags[flag_z];
            cond_ne:   cond_ok = !flags[flag_z];
            cond_cc:   cond_ok = !flags[flag_c];
            cond_cs:   cond_ok = flags[flag_c];
            cond_pl:   cond_ok = !flags[flag_n];
            cond_mi:   cond_ok = flags[flag_n];
            default:   cond_ok = 1'b0;
        endcase
    end

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            flags <= '0;
            valid <= 1'b0;
            wb_en <= 1'b0;
            read <= 1'b0;
            write <= 1'b0;
            branch <= 1'b0;
            taken <= 1'b0;
        end else if (!hold) begin
            if (d_valid && d_set_flags) begin
                flags[flag_n] <= alu_y[word_size-1];
                flags[flag_z] <= alu_y == '0;
                flags[flag_c] <= diff[word_size];
            end
            valid <= d_valid;
            wb_en <= d_wb_en;
            read <= d_read;
            write <= d_write;
            branch <= d_branch;
            taken <= d_branch && cond_ok;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            rd <= d_rd;
            result <= d_branch ? next_pc : alu_y;
            op2 <= d_op2;
            target <= next_pc + d_op2;
        end
    end
endmodule

/* logic/register_file.sv */
`timescale 1ns/1ns
/*
 eight general registers, two asynchronous read ports
 a write shows on the read ports from the next cycle, there is no bypass
*/
module register_file import isa_pkg::*; (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic [reg_bits-1:0]  raddr_x,
    input  logic [reg_bits-1:0]  raddr_y,
    input  logic                 wen,
    input  logic [reg_bits-1:0]  waddr,
    input  logic [word_size-1:0] wdata,
    output logic [word_size-1:0] rdata_x,
    output logic [word_size-1:0] rdata_y
);
    logic [word_size-1:0] regs [num_regs];

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_x = regs[raddr_x];
    assign rdata_y = regs[raddr_y];
endmodule

/* logic/decode_unit.sv */
`timescale 1ns/1ns
/*
 decode stage, one cycle
 operands are read with no bypass, so a read-after-write hazard against
 execute, memory or writeback stalls until the producer has retired
 cmp is op_other with the immediate flag set or bits 8..3 all zero
*/
module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 hold,
    input  logic                 branch_busy,
    input  logic                 fetch_valid,
    input  logic [word_size-1:0] fetch_word,
    input  logic [word_size-1:0] fetch_pc,
    input  logic [word_size-1:0] rdata_x,
    input  logic [word_size-1:0] rdata_y,
    input  logic [reg_bits-1:0]  ex_rd,
    input  logic                 ex_wb,
    input  logic [reg_bits-1:0]  mem_rd,
    input  logic                 mem_wb,
    input  logic [reg_bits-1:0]  wbk_rd,
    input  logic                 wbk_wb,
    output logic [reg_bits-1:0]  raddr_x,
    output logic [reg_bits-1:0]  raddr_y,
    output logic                 stall,
    output logic                 valid,
    output logic [reg_bits-1:0]  rd,
    output logic                 wb_en,
    output logic [word_size-1:0] op1,
    output logic [word_size-1:0] op2,
    output alu_op_t              alu_op,
    output logic                 set_flags,
    output logic                 read,
    output logic                 write,
    output logic                 branch,
    output cond_t                cond,
    output logic [word_size-1:0] pc
);
    opcode_t opcode;
    alu_op_t n_alu;
    logic imm_flag, use_x, use_y, live, take;
    logic n_valid, n_wb_en, n_flags, n_read, n_write, n_branch;
    logic hazard_x, hazard_y;
    logic [word_size-1:0] imm_ext, n_op2;

    assign opcode = opcode_t'(fetch_word[word_size-1:op_lsb]);
    assign imm_flag = fetch_word[imm_bit];
    assign raddr_x = fetch_word[rx_lsb+reg_bits-1:rx_lsb];
    assign raddr_y = fetch_word[reg_bits-1:0];
    assign imm_ext = {{(word_size-imm_width){fetch_word[imm_width-1]}},
                      fetch_word[imm_width-1:0]};

    always_comb begin
        n_valid = 1'b1;
        n_wb_en = 1'b0;
        n_flags = 1'b0;
        n_read = 1'b0;
        n_write = 1'b0;
        n_branch = 1'b0;
        n_alu = alu_none;
        use_x = 1'b1;
        use_y = !imm_flag;
        case (opcode)
            op_mv: begin
                n_wb_en = 1'b1;
                n_alu = alu_pass;
                use_x = 1'b0;       // rX is only written
            end
            op_branch: begin
                n_branch = !imm_flag && raddr_x <= cond_mi;
                n_valid = n_branch;
                use_x = 1'b0;       // rX field holds the condition
                use_y = 1'b0;
            end
            op_add: begin
                n_wb_en = 1'b1;
                n_alu = alu_add;
            end
            op_sub: begin
                n_wb_en = 1'b1;
                n_alu = alu_sub;
            end
            op_load: begin
                n_wb_en = 1'b1;
                n_read = 1'b1;
            end
            op_store: n_write = 1'b1;
            op_other: begin
                n_flags = imm_flag || fetch_word[imm_width-1:reg_bits] == '0;
                n_valid = n_flags;
                n_alu = alu_sub;
            end
            op_logic: n_valid = 1'b0;
        endcase
        n_op2 = (imm_flag || opcode == op_branch) ? imm_ext : rdata_y;
    end

    assign hazard_x = use_x && ((ex_wb && ex_rd == raddr_x) || (mem_wb && mem_rd == raddr_x)
                                || (wbk_wb && wbk_rd == raddr_x));
    assign hazard_y = use_y && ((ex_wb && ex_rd == raddr_y) || (mem_wb && mem_rd == raddr_y)
                                || (wbk_wb && wbk_rd == raddr_y));

    assign live = fetch_valid && n_valid && fetch_word != '0;
    assign stall = live && !branch_busy && (hazard_x || hazard_y);
    assign take = live && !branch_busy && !stall;   // otherwise a bubble goes out

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            valid <= 1'b0;
            wb_en <= 1'b0;
            set_flags <= 1'b0;
            read <= 1'b0;
            write <= 1'b0;
            branch <= 1'b0;
        end else if (!hold) begin
            valid <= take;
            wb_en <= take && n_wb_en;
            set_flags <= take && n_flags;
            read <= take && n_read;
            write <= take && n_write;
            branch <= take && n_branch;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            rd <= raddr_x;
            op1 <= rdata_x;
            op2 <= n_op2;
            alu_op <= n_alu;
            cond <= cond_t'(raddr_x);
            pc <= fetch_pc;
        end
    end
endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
/*
 one word per cycle, instr_in must be valid in the cycle instr_addr is shown
 the PC only changes through redirect while a branch is in flight
*/
module fetch_unit import isa_pkg::*; #(
    parameter logic [word_size-1:0] reset_addr = '0
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 hold,
    input  logic                 stall,
    input  logic                 branch_busy,
    input  logic                 redirect,
    input  logic [word_size-1:0] redirect_addr,
    input  logic [word_size-1:0] instr_in,
    output logic [word_size-1:0] instr_addr,
    output logic                 fetch_valid,
    output logic [word_size-1:0] fetch_word,
    output logic [word_size-1:0] fetch_pc
);
    logic [word_size-1:0] pc;
    logic advance;

    assign advance = !hold && !stall && !branch_busy;
    assign instr_addr = pc;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            pc <= reset_addr;
            fetch_valid <= 1'b0;
        end else if (!hold) begin
            if (redirect)
                pc <= redirect_addr;
            else if (advance)
                pc <= pc + 1'b1;
            if (branch_busy)
                fetch_valid <= 1'b0;   // word behind a branch is dropped
            else if (!stall)
                fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (advance) begin
            fetch_word <= instr_in;
            fetch_pc <= pc;
        end
    end

    // only bubbles trail a branch, so memory is idle when it retires
    assert property (@(posedge Clock) disable iff (Reset) redirect |-> !hold);
endmodule

/* logic/pipe_pkg.sv */
/*
 types private to the pipeline
 the flag vector has no overflow bit
*/
package pipe_pkg;
    typedef enum logic [1:0] {
        alu_none,   // first operand passes, for ld, st and branch
        alu_pass,   // second operand, for mv
        alu_add,
        alu_sub     // sub and cmp
    } alu_op_t;

    localparam int num_flags = 3;
    localparam int flag_n    = 2;
    localparam int flag_z    = 1;
    localparam int flag_c    = 0;
endpackage

/* logic/isa_pkg.sv */
/*
 instruction-set constants for the 16-bit, eight-register core
 layout: [15:13] opcode, [12] immediate flag, [11:9] rX or condition,
 [8:0] signed immediate, [2:0] rY when the immediate flag is clear
 an all-zero word is a nop
*/
package isa_pkg;
    localparam int word_size = 16;
    localparam int num_regs  = 8;
    localparam int reg_bits  = 3;

    // field positions
    localparam int op_lsb    = 13;
    localparam int imm_bit   = 12;
    localparam int rx_lsb    = 9;
    localparam int imm_width = 9;

    typedef enum logic [2:0] {
        op_mv     = 3'd0,
        op_branch = 3'd1,   // with the immediate flag set this is mvt, a nop here
        op_add    = 3'd2,
        op_sub    = 3'd3,
        op_load   = 3'd4,
        op_store  = 3'd5,
        op_logic  = 3'd6,   // nop
        op_other  = 3'd7    // cmp, anything else is a nop
    } opcode_t;

    // code 7 was the link condition and is reserved
    typedef enum logic [2:0] {
        cond_none = 3'd0, cond_eq, cond_ne, cond_cc, cond_cs, cond_pl, cond_mi
    } cond_t;
endpackage
